//--- Makefile
# Verilator build and run for the video output block

VERILATOR ?= verilator
TOP ?= vga_tb
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal

SIM := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' compile.f) $(wildcard dv/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): compile.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f compile.f

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
+incdir+dv
hdl/vga_pkg.sv
hdl/vga_timing.sv
hdl/scan_fetch.sv
hdl/color_expand.sv
hdl/vga_top.sv
dv/vga_tb.sv

//--- dv/vga_tb_ref.svh
/*
  Reference model and compare tasks for the video block testbench.
  Included inside vga_tb; works on its framebuffer copy, its
  captured frame and its error counters.
*/

`ifndef VGA_TB_REF_SVH
`define VGA_TB_REF_SVH

// expected channels for a visible screen position
// stored byte at column / 4 plus (row / 4) * FB_W
function automatic void expected_rgb(input int x, input int y, input bit dim,
		output vga_pkg::chan_t er, output vga_pkg::chan_t eg, output vga_pkg::chan_t eb);
	int addr;
	vga_pkg::pixel_t p;
	addr = (x / SCALE) + (y / SCALE) * vga_pkg::FB_W;
	p = image[addr];
	// 3-3-2 fields, msb aligned in 6 bits
	er = {p[7:5], 3'b000};
	eg = {p[4:2], 3'b000};
	eb = {p[1:0], 4'b0000};
	// odd display lines at half brightness
	if (dim && (y % 2 == 1)) begin
		er = er >> 1;
		eg = eg >> 1;
		eb = eb >> 1;
	end
endfunction

task automatic check_chan(input string what, input int x, input int y,
		input vga_pkg::chan_t exp, input vga_pkg::chan_t act);
	checks++;
	if (exp !== act) begin
		errors++;
		test_errors++;
		$display("CHECK FAILED %s %s x=%0d y=%0d expected 'h%02h actual 'h%02h",
			cur_test, what, x, y, exp, act);
	end
endtask

task automatic check_count(input string what, input int exp, input int act);
	checks++;
	if (exp != act) begin
		errors++;
		test_errors++;
		$display("CHECK FAILED %s %s expected %0d actual %0d", cur_test, what, exp, act);
	end
endtask

// every visible pixel of the captured frame against the model
task automatic compare_frame(input bit dim);
	int x;
	int y;
	vga_pkg::chan_t er;
	vga_pkg::chan_t eg;
	vga_pkg::chan_t eb;
	logic [17:0] px;
	for (y = 0; y < vga_pkg::V_VIS; y++) begin
		for (x = 0; x < vga_pkg::H_VIS; x++) begin
			expected_rgb(x, y, dim, er, eg, eb);
			px = shot[y * vga_pkg::H_VIS + x];
			check_chan("r", x, y, er, px[17:12]);
			check_chan("g", x, y, eg, px[11:6]);
			check_chan("b", x, y, eb, px[5:0]);
		end
	end
endtask

`endif

//--- dv/vga_tb.sv
/*
  Testbench for the video output block. Writes images over the CPU
  port, captures whole frames by following hs and vs, and compares
  every pixel and every blanking clock against the reference model.
*/

`timescale 1ns/1ns
`default_nettype none

module vga_tb;

	localparam int SCALE = 1 << vga_pkg::SCALE_LOG2;
	// clocks from an hs fall to the first visible pixel
	localparam int FIRST_COL = vga_pkg::H_SYNC + vga_pkg::H_BP;
	// line index of display line 0
	// the hs fall that comes with the vs rise is index 0
	localparam int FIRST_LINE = vga_pkg::V_SYNC + vga_pkg::V_BP - 1;
	localparam int LINE_LIMIT = 2 * vga_pkg::H_TOTAL;
	localparam int FRAME_LIMIT = 2 * vga_pkg::H_TOTAL * vga_pkg::V_TOTAL;
	localparam bit SEL_HS = 1'b0;
	localparam bit SEL_VS = 1'b1;

	logic pclk;
	logic rst;
	logic cpu_clk;
	logic cpu_wr;
	vga_pkg::vaddr_t cpu_addr;
	vga_pkg::pixel_t cpu_data;
	logic scanlines;
	logic hs;
	logic vs;
	vga_pkg::chan_t r;
	vga_pkg::chan_t g;
	vga_pkg::chan_t b;

	// testbench copy of the framebuffer and the last captured frame
	vga_pkg::pixel_t image [vga_pkg::FB_DEPTH];
	logic [17:0] shot [vga_pkg::H_VIS * vga_pkg::V_VIS];

	string cur_test;
	int checks;
	int errors;
	int test_errors;
	int tests;
	int failed_tests;
	bit abort;

	`include "vga_tb_ref.svh"

	vga_top dut (
		.pclk(pclk),
		.rst(rst),
		.cpu_clk(cpu_clk),
		.cpu_wr(cpu_wr),
		.cpu_addr(cpu_addr),
		.cpu_data(cpu_data),
		.scanlines(scanlines),
		.hs(hs),
		.vs(vs),
		.r(r),
		.g(g),
		.b(b)
	);

	initial begin
		pclk = 1'b0;
		forever #5 pclk = ~pclk;
	end

	// cpu clock unrelated to pclk
	initial begin
		cpu_clk = 1'b0;
		forever #7 cpu_clk = ~cpu_clk;
	end

	// waits on falling pclk edges for an hs or vs edge
	task automatic wait_edge(input bit sel, input bit rising, input int limit,
			output int clocks);
		logic prev;
		logic cur;
		bit seen;
		clocks = 0;
		seen = 1'b0;
		prev = sel ? vs : hs;
		while (!seen && !abort) begin
			@(negedge pclk);
			clocks++;
			cur = sel ? vs : hs;
			if (cur != prev && cur == rising) begin
				seen = 1'b1;
			end
			prev = cur;
			if (!seen && clocks >= limit) begin
				$display("%s: timeout, no %s %s edge within %0d clocks", cur_test,
					sel ? "vs" : "hs", rising ? "rising" : "falling", limit);
				errors++;
				test_errors++;
				abort = 1'b1;
			end
		end
	endtask

	// one byte per cpu clock, taken by the DUT on the next edge
	task automatic write_byte(input int addr, input vga_pkg::pixel_t data);
		@(posedge cpu_clk);
		cpu_wr <= 1'b1;
		cpu_addr <= vga_pkg::vaddr_t'(addr);
		cpu_data <= data;
	endtask

	task automatic write_idle();
		@(posedge cpu_clk);
		cpu_wr <= 1'b0;
	endtask

	// whole testbench image into the framebuffer
	task automatic load_image();
		int a;
		for (a = 0; a < vga_pkg::FB_DEPTH; a++) begin
			write_byte(a, image[a]);
		end
		write_idle();
	endtask

	// one frame from a vs rise with one line per hs fall
	// visible pixels go to shot
	// all other clocks must be black
	task automatic scan_frame();
		int n;
		int line;
		int t;
		int x;
		int y;
		wait_edge(SEL_VS, 1'b1, FRAME_LIMIT, n);
		for (line = 0; line < vga_pkg::V_TOTAL && !abort; line++) begin
			if (line > 0) begin
				wait_edge(SEL_HS, 1'b0, LINE_LIMIT, n);
			end
			y = line - FIRST_LINE;
			for (t = 0; t < vga_pkg::H_TOTAL && !abort; t++) begin
				if (t > 0) begin
					@(negedge pclk);
				end
				x = t - FIRST_COL;
				if (y >= 0 && y < vga_pkg::V_VIS && x >= 0 && x < vga_pkg::H_VIS) begin
					shot[y * vga_pkg::H_VIS + x] = {r, g, b};
				end else begin
					check_chan("blank r", t, line, '0, r);
					check_chan("blank g", t, line, '0, g);
					check_chan("blank b", t, line, '0, b);
				end
			end
		end
	endtask

	// matches of one stored pixel in an 8 position window
	function automatic int run_length(input int x0, input int y0, input int dx,
			input int dy, input int ref_x, input int ref_y);
		int i;
		int n;
		vga_pkg::chan_t er;
		vga_pkg::chan_t eg;
		vga_pkg::chan_t eb;
		expected_rgb(ref_x, ref_y, 1'b0, er, eg, eb);
		n = 0;
		for (i = 0; i < 2 * SCALE; i++) begin
			if (shot[(y0 + i * dy) * vga_pkg::H_VIS + x0 + i * dx] == {er, eg, eb}) begin
				n++;
			end
		end
		return n;
	endfunction

	// one summary line per test
	task automatic end_test();
		tests++;
		if (test_errors != 0) begin
			failed_tests++;
		end
		$display("%s: %s, %0d errors", cur_test, (test_errors == 0) ? "passed" : "failed",
			test_errors);
		test_errors = 0;
	endtask

	task automatic sync_timing();
		int n;
		int low;
		int high;
		cur_test = "sync_timing";
		wait_edge(SEL_HS, 1'b0, LINE_LIMIT, n);
		wait_edge(SEL_HS, 1'b1, LINE_LIMIT, low);
		check_count("hs low width", vga_pkg::H_SYNC, low);
		wait_edge(SEL_HS, 1'b0, LINE_LIMIT, n);
		check_count("hs period", vga_pkg::H_TOTAL, low + n);
		// vs lengths in clocks as whole hs periods
		wait_edge(SEL_VS, 1'b1, FRAME_LIMIT, n);
		wait_edge(SEL_VS, 1'b0, FRAME_LIMIT, high);
		check_count("vs high width", vga_pkg::V_SYNC * vga_pkg::H_TOTAL, high);
		wait_edge(SEL_VS, 1'b1, FRAME_LIMIT, n);
		check_count("vs period", vga_pkg::V_TOTAL * vga_pkg::H_TOTAL, high + n);
		end_test();
	endtask

	// fresh random image, one frame with or without dimming
	task automatic random_frame(input string name, input bit dim);
		int a;
		cur_test = name;
		for (a = 0; a < vga_pkg::FB_DEPTH; a++) begin
			image[a] = vga_pkg::pixel_t'($urandom);
		end
		load_image();
		@(posedge pclk);
		scanlines <= dim;
		scan_frame();
		compare_frame(dim);
		@(posedge pclk);
		scanlines <= 1'b0;
		end_test();
	endtask

	task automatic scaling();
		int col;
		int row;
		cur_test = "scaling";
		// neighbours differ by 1 across and 3 down
		for (row = 0; row < vga_pkg::FB_H; row++) begin
			for (col = 0; col < vga_pkg::FB_W; col++) begin
				image[row * vga_pkg::FB_W + col] = vga_pkg::pixel_t'(col + 3 * row);
			end
		end
		load_image();
		scan_frame();
		compare_frame(1'b0);
		// last stored column and row against the neighbouring block
		check_count("last col width", SCALE, run_length(632, 399, 1, 0, 639, 399));
		check_count("last row height", SCALE, run_length(639, 392, 0, 1, 639, 399));
		check_count("last col top height", SCALE, run_length(639, 0, 0, 1, 639, 0));
		check_count("last row left width", SCALE, run_length(0, 399, 1, 0, 0, 399));
		end_test();
	endtask

	// a few random bytes over the previous image
	task automatic rewrite();
		int a;
		vga_pkg::pixel_t d;
		cur_test = "rewrite";
		repeat (200) begin
			a = $urandom_range(vga_pkg::FB_DEPTH - 1);
			d = vga_pkg::pixel_t'($urandom);
			image[a] = d;
			write_byte(a, d);
		end
		write_idle();
		scan_frame();
		compare_frame(1'b0);
		end_test();
	endtask

	task automatic out_of_range();
		int a;
		cur_test = "out_of_range";
		// inverted data shows up if the address aliases
		repeat (32) begin
			a = vga_pkg::FB_DEPTH + $urandom_range(16383 - vga_pkg::FB_DEPTH);
			write_byte(a, ~image[a - vga_pkg::FB_DEPTH]);
		end
		write_idle();
		scan_frame();
		compare_frame(1'b0);
		end_test();
	endtask

	initial begin
		void'($urandom(32'he462_38fc));
		rst = 1'b1;
		cpu_wr = 1'b0;
		cpu_addr = '0;
		cpu_data = '0;
		scanlines = 1'b0;
		checks = 0;
		errors = 0;
		test_errors = 0;
		tests = 0;
		failed_tests = 0;
		abort = 1'b0;
		repeat (4) @(posedge pclk);
		rst <= 1'b0;
		@(negedge pclk);
		cur_test = "reset_values";
		// unknown sync levels count as wrong
		check_count("hs level", 1, int'(hs === 1'b1));
		check_count("vs level", 0, int'(vs !== 1'b0));
		check_chan("r", 0, 0, '0, r);
		check_chan("g", 0, 0, '0, g);
		check_chan("b", 0, 0, '0, b);
		end_test();
		if (!abort) sync_timing();
		if (!abort) random_frame("random_image", 1'b0);
		if (!abort) scaling();
		if (!abort) random_frame("scanlines", 1'b1);
		if (!abort) rewrite();
		if (!abort) out_of_range();
		$display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed_tests,
			checks, errors);
		if (errors == 0 && !abort) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/color_expand.sv
/*
  Output colour stage. Delays the raw syncs to line up with the
  fetched pixel, expands rgb 3-3-2 to 6 bits per channel and halves
  odd display lines when scanlines is set.
*/

`timescale 1ns/1ns
`default_nettype none

module color_expand (
	input wire pclk,
	input wire rst,
	input wire scanlines,
	input vga_pkg::vpos_t v_cnt,
	input wire hs_raw,
	input wire vs_raw,
	input vga_pkg::pixel_t pixel,
	output logic hs,
	output logic vs,
	output vga_pkg::chan_t r,
	output vga_pkg::chan_t g,
	output vga_pkg::chan_t b
);

	// line parity, delayed like the pixel
	logic line_odd;
	logic dim;

	// full brightness channels
	vga_pkg::chan_t r_full;
	vga_pkg::chan_t g_full;
	vga_pkg::chan_t b_full;

	// msbs of each field, padded with zeros
	assign r_full = {pixel[7:5], 3'b000};
	assign g_full = {pixel[4:2], 3'b000};
	assign b_full = {pixel[1:0], 4'b0000};

	assign dim = scanlines && line_odd;

	always_ff @(posedge pclk) begin
		if (rst) begin
			line_odd <= 1'b0;
			hs <= 1'b1;
			vs <= 1'b0;
			r <= '0;
			g <= '0;
			b <= '0;
		end else begin
			line_odd <= v_cnt[0];
			// one clock to match the fetch
			hs <= hs_raw;
			vs <= vs_raw;
			// half brightness on odd lines
			r <= dim ? (r_full >> 1) : r_full;
			g <= dim ? (g_full >> 1) : g_full;
			b <= dim ? (b_full >> 1) : b_full;
		end
	end

endmodule

`default_nettype wire

//--- hdl/scan_fetch.sv
/*
  Framebuffer and scan fetch. The CPU writes bytes on cpu_clk.
  The display side walks the buffer on pclk, one stored pixel per
  four columns, and repeats each stored row on four lines.
*/

`timescale 1ns/1ns
`default_nettype none

module scan_fetch (
	input wire pclk,
	input wire rst,
	input wire cpu_clk,
	input wire cpu_wr,
	input vga_pkg::vaddr_t cpu_addr,
	input vga_pkg::pixel_t cpu_data,
	input vga_pkg::hpos_t h_cnt,
	input vga_pkg::vpos_t v_cnt,
	output vga_pkg::pixel_t pixel
);

	// 160x100 bytes of video memory
	vga_pkg::pixel_t vmem [vga_pkg::FB_DEPTH];

	// current read position in the framebuffer
	vga_pkg::vaddr_t scan_addr;

	logic visible;
	logic last_col_of_block;
	logic last_line_of_block;
	logic hsync_start;
	logic vsync_line;
	logic wr_in_range;

	assign visible = (h_cnt < vga_pkg::hpos_t'(vga_pkg::H_VIS)) &&
		(v_cnt < vga_pkg::vpos_t'(vga_pkg::V_VIS));

	// low counter bits all ones on the 4th column / line of a block
	assign last_col_of_block = &h_cnt[vga_pkg::SCALE_LOG2-1:0];
	assign last_line_of_block = &v_cnt[vga_pkg::SCALE_LOG2-1:0];

	assign hsync_start = (h_cnt == vga_pkg::hpos_t'(vga_pkg::H_VIS + vga_pkg::H_FP));
	assign vsync_line = (v_cnt == vga_pkg::vpos_t'(vga_pkg::V_VIS + vga_pkg::V_FP));

	// writes past the end of the buffer are dropped
	assign wr_in_range = (cpu_addr < vga_pkg::vaddr_t'(vga_pkg::FB_DEPTH));

	// cpu write port
	always_ff @(posedge cpu_clk) begin
		if (cpu_wr && wr_in_range) begin
			vmem[cpu_addr] <= cpu_data;
		end
	end

	// scan address
	// +1 after every 4th visible column
	// back one stored row at hsync on 3 of 4 lines
	// back to 0 at vsync
	always_ff @(posedge pclk) begin
		if (rst) begin
			scan_addr <= '0;
		end else if (visible) begin
			if (last_col_of_block) begin
				scan_addr <= scan_addr + 1'b1;
			end
		end else if (hsync_start) begin
			if (vsync_line) begin
				scan_addr <= '0;
			end else if ((v_cnt < vga_pkg::vpos_t'(vga_pkg::V_VIS)) &&
				!last_line_of_block) begin
				scan_addr <= scan_addr - vga_pkg::vaddr_t'(vga_pkg::FB_W);
			end
		end
	end

	// read port, one cycle behind the raster position
	// black in porch and sync
	always_ff @(posedge pclk) begin
		if (rst) begin
			pixel <= '0;
		end else if (visible) begin
			pixel <= vmem[scan_addr];
		end else begin
			pixel <= '0;
		end
	end

endmodule

`default_nettype wire

//--- hdl/vga_pkg.sv
/*
  Shared definitions for the 160x100 framebuffer video block.
  Holds the 640x400 mode timing, the framebuffer geometry and the
  width types used on the ports between the display modules.
*/

`default_nettype none

package vga_pkg;

	// raster column and line counters
	typedef logic [9:0] hpos_t;
	typedef logic [9:0] vpos_t;

	// framebuffer byte address
	typedef logic [13:0] vaddr_t;

	// stored pixel, rgb 3-3-2
	typedef logic [7:0] pixel_t;

	// one output colour channel
	typedef logic [5:0] chan_t;

	// horizontal timing in pclk cycles
	localparam int H_VIS = 640;
	localparam int H_FP = 16;
	localparam int H_SYNC = 96;
	localparam int H_BP = 48;
	localparam int H_TOTAL = H_VIS + H_FP + H_SYNC + H_BP;

	// vertical timing in lines
	localparam int V_VIS = 400;
	localparam int V_FP = 12;
	localparam int V_SYNC = 2;
	localparam int V_BP = 35;
	localparam int V_TOTAL = V_VIS + V_FP + V_SYNC + V_BP;

	// framebuffer geometry, stored pixels
	localparam int FB_W = 160;
	localparam int FB_H = 100;
	localparam int FB_DEPTH = FB_W * FB_H;

	// each stored pixel covers a 4x4 screen block
	localparam int SCALE_LOG2 = 2;

endpackage

`default_nettype wire

//--- hdl/vga_timing.sv
/*
  Raster timing generator for the 640x400 mode at about 70 Hz.
  Counts columns and lines from the start of the visible area and
  registers the raw sync levels. Hsync is active low, vsync high.
*/

`timescale 1ns/1ns
`default_nettype none

module vga_timing (
	input wire pclk,
	input wire rst,
	output vga_pkg::hpos_t h_cnt,
	output vga_pkg::vpos_t v_cnt,
	output logic hs_raw,
	output logic vs_raw
);

	// boundary markers on the column counter
	logic h_last;
	logic hsync_start;
	logic hsync_end;

	// boundary markers on the line counter
	logic v_last;
	logic vsync_start;
	logic vsync_end;

	assign h_last = (h_cnt == vga_pkg::hpos_t'(vga_pkg::H_TOTAL - 1));
	assign hsync_start = (h_cnt == vga_pkg::hpos_t'(vga_pkg::H_VIS + vga_pkg::H_FP));
	assign hsync_end = (h_cnt ==
		vga_pkg::hpos_t'(vga_pkg::H_VIS + vga_pkg::H_FP + vga_pkg::H_SYNC));

	assign v_last = (v_cnt == vga_pkg::vpos_t'(vga_pkg::V_TOTAL - 1));
	assign vsync_start = (v_cnt == vga_pkg::vpos_t'(vga_pkg::V_VIS + vga_pkg::V_FP));
	assign vsync_end = (v_cnt ==
		vga_pkg::vpos_t'(vga_pkg::V_VIS + vga_pkg::V_FP + vga_pkg::V_SYNC));

	// column counter, free running
	always_ff @(posedge pclk) begin
		if (rst) begin
			h_cnt <= '0;
		end else if (h_last) begin
			h_cnt <= '0;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// hsync low from the end of the front porch
	always_ff @(posedge pclk) begin
		if (rst) begin
			hs_raw <= 1'b1;
		end else if (hsync_start) begin
			hs_raw <= 1'b0;
		end else if (hsync_end) begin
			hs_raw <= 1'b1;
		end
	end

	// line counter steps once per line
	// at the start of horizontal sync
	always_ff @(posedge pclk) begin
		if (rst) begin
			v_cnt <= '0;
		end else if (hsync_start) begin
			if (v_last) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + 1'b1;
			end
		end
	end

	// vsync high for two lines
	// edges line up with an hsync fall
	always_ff @(posedge pclk) begin
		if (rst) begin
			vs_raw <= 1'b0;
		end else if (hsync_start) begin
			if (vsync_start) begin
				vs_raw <= 1'b1;
			end else if (vsync_end) begin
				vs_raw <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/vga_top.sv
/*
  Top of the video output block. Connects the raster timing, the
  framebuffer fetch and the colour stage. Outputs are two pclk cycles
  behind the raster position they belong to.
*/

`timescale 1ns/1ns
`default_nettype none

module vga_top (
	// display clock and reset
	input wire pclk,
	input wire rst,

	// cpu write port, write only
	input wire cpu_clk,
	input wire cpu_wr,
	input vga_pkg::vaddr_t cpu_addr,
	input vga_pkg::pixel_t cpu_data,

	// level, dims odd lines
	input wire scanlines,

	// vga monitor side
	output logic hs,
	output logic vs,
	output vga_pkg::chan_t r,
	output vga_pkg::chan_t g,
	output vga_pkg::chan_t b
);

	// raster position
	vga_pkg::hpos_t h_cnt;
	vga_pkg::vpos_t v_cnt;

	// registered syncs before alignment
	logic hs_raw;
	logic vs_raw;

	// fetched pixel, black outside the visible area
	vga_pkg::pixel_t pixel;

	vga_timing u_timing (
		.pclk(pclk),
		.rst(rst),
		.h_cnt(h_cnt),
		.v_cnt(v_cnt),
		.hs_raw(hs_raw),
		.vs_raw(vs_raw)
	);

	// framebuffer, crosses from cpu_clk to pclk
	scan_fetch u_fetch (
		.pclk(pclk),
		.rst(rst),
		.cpu_clk(cpu_clk),
		.cpu_wr(cpu_wr),
		.cpu_addr(cpu_addr),
		.cpu_data(cpu_data),
		.h_cnt(h_cnt),
		.v_cnt(v_cnt),
		.pixel(pixel)
	);

	color_expand u_color (
		.pclk(pclk),
		.rst(rst),
		.scanlines(scanlines),
		.v_cnt(v_cnt),
		.hs_raw(hs_raw),
		.vs_raw(vs_raw),
		.pixel(pixel),
		.hs(hs),
		.vs(vs),
		.r(r),
		.g(g),
		.b(b)
	);

endmodule

`default_nettype wire
